/* src.f */
src/uartPkg.sv
src/textPkg.sv
src/uartRx.sv
src/caseFilter.sv
src/uartTx.sv
src/uartEcho.sv
test/clockGen.sv
test/uartEcho_props.sv
test/uartEchoTb.sv

/* test/uartEchoTb.sv */
`timescale 1ns/1ps

module uartEchoTb;

    localparam int CLKS           = uartPkg::CLKS_PER_BIT;
    localparam int GAP            = 2 * CLKS;
    localparam int SHORT_STOP     = 12;  // frames arrive a little faster than they leave.
    localparam int NUM_FRAMES     = 101;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * CLKS * 2 + 4000;

    logic           clk;
    logic           rstN;
    logic           rxLine;
    logic           txLine;
    logic           framingError;
    logic           overrun;
    logic [31:0]    lfsr;
    textPkg::mode_t refMode;
    logic [7:0]     expectQ[$];
    string          testName;
    int             framingCount = 0;
    int             overrunCount = 0;
    int             cycleCount = 0;

    clockGen i_clockGen (.clk(clk), .rstN(rstN));

    uartEcho i_uartEcho (
        .clk          (clk),
        .rstN         (rstN),
        .rxLine       (rxLine),
        .txLine       (txLine),
        .framingError (framingError),
        .overrun      (overrun)
    );

    bind uartEcho uartEcho_props i_uartEchoProps (
        .clk(clk), .rstN(rstN), .txLine(txLine), .framingError(framingError),
        .overrun(overrun), .rxValid(rxValid), .txData(txData), .txValid(txValid),
        .txReady(txReady)
    );

    task automatic stopWithError(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string name, input int expected, input int actual);
        stopWithError($sformatf("Fail %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
    endtask

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic randomChar(output logic [6:0] c);
        for (int i = 0; i < 7; i++) begin
            lfsr = lfsrNext(lfsr);
            c[i] = lfsr[0];
        end
    endtask

    // expected echo of one character under the given mode.
    function automatic logic [7:0] filtered(input textPkg::mode_t m, input logic [6:0] c);
        if (m == textPkg::MODE_UPPER && c >= "a" && c <= "z") begin
            return {1'b0, c - 7'd32};
        end else if (m == textPkg::MODE_LOWER && c >= "A" && c <= "Z") begin
            return {1'b0, c + 7'd32};
        end
        return {1'b0, c};
    endfunction

    function automatic logic [7:0] makeCommand(input logic [2:0] opcode, input logic [3:0] arg);
        textPkg::textByte_t b;
        b.cmd.isCmd  = 1'b1;
        b.cmd.opcode = opcode;
        b.cmd.arg    = arg;
        return b;
    endfunction

    // called 1 ns after a rising edge, returns at the same phase.
    task automatic driveBit(input logic v, input int cycles);
        rxLine = v;
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    task automatic sendFrame(input logic [7:0] b, input logic badStop, input int stopCycles);
        driveBit(1'b0, CLKS);
        for (int i = 0; i < 8; i++) begin
            driveBit(b[i], CLKS);
        end
        driveBit(!badStop, stopCycles);
    endtask

    task automatic sendData(input logic [6:0] c);
        expectQ.push_back(filtered(refMode, c));
        sendFrame({1'b0, c}, 1'b0, CLKS);
        driveBit(1'b1, GAP);
    endtask

    task automatic sendText(input string s);
        logic [7:0] ch;
        for (int i = 0; i < s.len(); i++) begin
            ch = s[i];
            sendData(ch[6:0]);
        end
    endtask

    task automatic sendCommand(input logic [7:0] b);
        textPkg::textByte_t t;
        t = b;
        if (t.cmd.opcode == textPkg::OP_SET_MODE && t.cmd.arg <= 4'd2) begin
            refMode = textPkg::mode_t'(t.cmd.arg[1:0]);
        end
        sendFrame(b, 1'b0, CLKS);
        driveBit(1'b1, GAP);
    endtask

    task automatic drainOutput();
        while (expectQ.size() != 0) begin
            @(posedge clk);
            #1;
        end
        driveBit(1'b1, GAP);
    endtask

    // decodes txLine at mid-bit.
    initial begin : txMonitor
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge clk);
            if (rstN === 1'b1 && txLine === 1'b0) begin
                repeat (uartPkg::HALF_BIT - 1) @(negedge clk);
                assert (txLine === 1'b0) else stopWithError("start bit on txLine is too short");
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    got[i] = txLine;
                end
                repeat (CLKS) @(negedge clk);
                assert (txLine === 1'b1) else stopWithError("stop bit on txLine is low");
                assert (expectQ.size() > 0) else stopWithError("txLine sent an unexpected byte");
                want = expectQ.pop_front();
                assert (got === want) else reportMismatch(testName, want, got);
            end
        end
    end

    always @(negedge clk) begin
        if (rstN === 1'b1 && framingError === 1'b1) begin
            framingCount++;
        end
        if (rstN === 1'b1 && overrun === 1'b1) begin
            overrunCount++;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_CYCLES) begin
            stopWithError("timeout, the run did not finish within the expected number of cycles");
        end
    end

    initial begin : stimulus
        logic [6:0] c;
        rxLine   = 1'b1;
        lfsr     = 32'h1894_c822;
        refMode  = textPkg::MODE_PASS;
        testName = "reset";
        wait (rstN === 1'b1);
        @(posedge clk);
        #1;

        testName = "passThrough";
        for (int i = 0; i < 20; i++) begin
            randomChar(c);
            sendData(c);
        end

        testName = "upperCase";
        sendCommand(makeCommand(textPkg::OP_SET_MODE, 4'(textPkg::MODE_UPPER)));
        sendText("Hello, World 42!");

        testName = "lowerCase";
        sendCommand(makeCommand(textPkg::OP_SET_MODE, 4'(textPkg::MODE_LOWER)));
        sendText("MiXeD Case #7 ok");
        sendCommand(makeCommand(3'd5, 4'(textPkg::MODE_UPPER)));  // unknown opcode.
        sendCommand(makeCommand(textPkg::OP_SET_MODE, 4'd9));  // unknown mode.
        sendText("AbC");

        testName = "framingError";
        sendFrame(8'h58, 1'b1, CLKS);
        driveBit(1'b1, GAP);
        assert (framingCount == 1) else reportMismatch(testName, 1, framingCount);
        sendData(7'h4b);

        // the tail of identical bytes absorbs the one that the full buffer drops.
        testName = "overrun";
        drainOutput();
        for (int i = 0; i < 40; i++) begin
            if (i < 22) begin
                randomChar(c);
            end else begin
                c = 7'h51;
            end
            if (i < 39) begin
                expectQ.push_back(filtered(refMode, c));
            end
            sendFrame({1'b0, c}, 1'b0, SHORT_STOP);
        end
        driveBit(1'b1, GAP);

        drainOutput();
        driveBit(1'b1, 10 * CLKS);
        assert (overrunCount == 1) else reportMismatch("overrunCount", 1, overrunCount);
        assert (framingCount == 1) else reportMismatch("framingCount", 1, framingCount);
        if (expectQ.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stopWithError("bytes still expected on txLine at the end of the run");
        end
    end

endmodule

/* test/uartEcho_props.sv */
`timescale 1ns/1ps

module uartEcho_props (
    input logic       clk,
    input logic       rstN,
    input logic       txLine,
    input logic       framingError,
    input logic       overrun,
    input logic       rxValid,
    input logic [7:0] txData,
    input logic       txValid,
    input logic       txReady
);

    // the transmitter is idle exactly when it is ready.
    idleLineHigh: assert property (@(posedge clk) disable iff (!rstN) txReady |-> txLine)
        else $error("txLine low while the transmitter is idle");

    offerHeld: assert property (@(posedge clk) disable iff (!rstN)
        txValid && !txReady |=> txValid && $stable(txData))
        else $error("txValid or txData changed before the transfer");

    errorsApart: assert property (@(posedge clk) disable iff (!rstN)
        !(framingError && overrun))
        else $error("framingError and overrun high in the same cycle");

    rxPulseApart: assert property (@(posedge clk) disable iff (!rstN)
        !(rxValid && framingError))
        else $error("rxValid and framingError high in the same cycle");

endmodule

/* test/clockGen.sv */
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        #1 rstN = 1'b1;  // released just after the second edge.
    end

    always #4 clk = ~clk;  // 8 ns period.

endmodule

/* src/uartEcho.sv */
`timescale 1ns/1ps

module uartEcho (
    input  logic clk,
    input  logic rstN,
    input  logic rxLine,
    output logic txLine,
    output logic framingError,
    output logic overrun
);

    logic [uartPkg::DATA_BITS-1:0] rxData;
    logic                          rxValid;
    logic [uartPkg::DATA_BITS-1:0] txData;
    logic                          txValid;
    logic                          txReady;

    uartRx i_uartRx (
        .clk          (clk),
        .rstN         (rstN),
        .rxLine       (rxLine),
        .rxData       (rxData),
        .rxValid      (rxValid),
        .framingError (framingError)
    );

    caseFilter i_caseFilter (
        .clk     (clk),
        .rstN    (rstN),
        .rxData  (rxData),
        .rxValid (rxValid),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .overrun (overrun)
    );

    uartTx i_uartTx (
        .clk     (clk),
        .rstN    (rstN),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .txLine  (txLine)
    );

endmodule

/* src/uartTx.sv */
`timescale 1ns/1ps

module uartTx (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [uartPkg::DATA_BITS-1:0] txData,
    input  logic                          txValid,
    output logic                          txReady,
    output logic                          txLine
);

    logic                          busy;
    logic [uartPkg::COUNT_W-1:0]   bitTimer;
    logic [uartPkg::FRAME_W-1:0]   bitCnt;
    logic [uartPkg::DATA_BITS:0]   frame;  // bits still to send, stop bit on top.
    logic                          bitDone;
    logic                          lastBit;

    assign txReady = !busy;
    assign bitDone = (bitTimer == uartPkg::COUNT_W'(uartPkg::CLKS_PER_BIT - 1));
    assign lastBit = (bitCnt == uartPkg::FRAME_W'(uartPkg::FRAME_BITS - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy     <= 1'b0;
            txLine   <= 1'b1;
            bitTimer <= '0;
            bitCnt   <= '0;
        end else if (!busy) begin
            if (txValid) begin
                busy     <= 1'b1;
                txLine   <= 1'b0;  // start bit.
                bitTimer <= '0;
                bitCnt   <= '0;
            end
        end else if (bitDone) begin
            bitTimer <= '0;
            if (lastBit) begin
                busy <= 1'b0;  // stop bit done, line stays high.
            end else begin
                txLine <= frame[0];
                bitCnt <= bitCnt + 1'b1;
            end
        end else begin
            bitTimer <= bitTimer + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && txValid) begin
            frame <= {1'b1, txData};
        end else if (busy && bitDone) begin
            frame <= {1'b1, frame[uartPkg::DATA_BITS:1]};
        end
    end

endmodule

/* src/caseFilter.sv */
`timescale 1ns/1ps

module caseFilter (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic [uartPkg::DATA_BITS-1:0] rxData,
    input  logic                          rxValid,
    output logic [uartPkg::DATA_BITS-1:0] txData,
    output logic                          txValid,
    input  logic                          txReady,
    output logic                          overrun
);

    textPkg::textByte_t inByte;
    textPkg::mode_t     mode;
    logic [6:0]         outCode;
    logic               accept;

    assign inByte = rxData;
    assign accept = rxValid && !txValid;  // buffer full drops the byte.

    always_comb begin
        outCode = inByte.chr.code;
        if (mode == textPkg::MODE_UPPER && inByte.chr.code >= textPkg::LOWER_A &&
            inByte.chr.code <= textPkg::LOWER_Z) begin
            outCode = inByte.chr.code ^ textPkg::CASE_BIT;
        end else if (mode == textPkg::MODE_LOWER && inByte.chr.code >= textPkg::UPPER_A &&
                     inByte.chr.code <= textPkg::UPPER_Z) begin
            outCode = inByte.chr.code ^ textPkg::CASE_BIT;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mode    <= textPkg::MODE_PASS;
            txValid <= 1'b0;
            overrun <= 1'b0;
        end else begin
            overrun <= rxValid && txValid;
            if (txValid && txReady) begin
                txValid <= 1'b0;
            end
            if (accept) begin
                if (inByte.cmd.isCmd) begin
                    if (inByte.cmd.opcode == textPkg::OP_SET_MODE) begin
                        case (inByte.cmd.arg)
                            4'(textPkg::MODE_PASS),
                            4'(textPkg::MODE_UPPER),
                            4'(textPkg::MODE_LOWER): begin
                                mode <= textPkg::mode_t'(inByte.cmd.arg[1:0]);
                            end
                            default: begin
                                mode <= mode;  // unknown argument.
                            end
                        endcase
                    end
                end else begin
                    txValid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !inByte.cmd.isCmd) begin
            txData <= {1'b0, outCode};
        end
    end

endmodule

/* src/uartRx.sv */
`timescale 1ns/1ps

module uartRx (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          rxLine,
    output logic [uartPkg::DATA_BITS-1:0] rxData,
    output logic                          rxValid,
    output logic                          framingError
);

    logic [1:0]                      rxSync;
    logic                            rxIn;
    logic [2:0]                      state;
    logic [uartPkg::COUNT_W-1:0]     bitTimer;
    logic [uartPkg::BIT_IDX_W-1:0]   bitIdx;
    logic                            halfDone;
    logic                            bitDone;

    assign rxIn     = rxSync[1];
    assign halfDone = (bitTimer == uartPkg::COUNT_W'(uartPkg::HALF_BIT - 1));
    assign bitDone  = (bitTimer == uartPkg::COUNT_W'(uartPkg::CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxSync <= 2'b11;  // idle line level.
        end else begin
            rxSync <= {rxSync[0], rxLine};
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state        <= uartPkg::RX_IDLE;
            bitTimer     <= '0;
            bitIdx       <= '0;
            rxValid      <= 1'b0;
            framingError <= 1'b0;
        end else begin
            rxValid      <= 1'b0;
            framingError <= 1'b0;
            case (state)
                uartPkg::RX_IDLE: begin
                    bitTimer <= '0;
                    if (!rxIn) begin
                        state <= uartPkg::RX_START;
                    end
                end
                uartPkg::RX_START: begin
                    if (halfDone) begin
                        bitTimer <= '0;
                        bitIdx   <= '0;
                        state    <= rxIn ? uartPkg::RX_IDLE : uartPkg::RX_DATA;  // high is a glitch.
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                uartPkg::RX_DATA: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        bitIdx   <= bitIdx + 1'b1;
                        if (&bitIdx) begin
                            state <= uartPkg::RX_STOP;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                uartPkg::RX_STOP: begin
                    if (bitDone) begin
                        bitTimer <= '0;
                        if (rxIn) begin
                            rxValid <= 1'b1;
                            state   <= uartPkg::RX_IDLE;
                        end else begin
                            framingError <= 1'b1;
                            state        <= uartPkg::RX_WAIT;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                uartPkg::RX_WAIT: begin
                    if (rxIn) begin
                        state <= uartPkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= uartPkg::RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first, so shift in from the top.
    always_ff @(posedge clk) begin
        if (state == uartPkg::RX_DATA && bitDone) begin
            rxData <= {rxIn, rxData[uartPkg::DATA_BITS-1:1]};
        end
    end

endmodule

/* src/textPkg.sv */
package textPkg;

    localparam logic [2:0] OP_SET_MODE = 3'd0;

    typedef enum logic [1:0] {
        MODE_PASS  = 2'd0,
        MODE_UPPER = 2'd1,
        MODE_LOWER = 2'd2
    } mode_t;

    // ascii letter ranges.
    localparam logic [6:0] UPPER_A  = 7'h41;
    localparam logic [6:0] UPPER_Z  = 7'h5a;
    localparam logic [6:0] LOWER_A  = 7'h61;
    localparam logic [6:0] LOWER_Z  = 7'h7a;
    localparam logic [6:0] CASE_BIT = 7'h20;  // only difference between the two cases.

    typedef struct packed {
        logic       isCmd;
        logic [6:0] code;
    } chrView_t;

    typedef struct packed {
        logic       isCmd;
        logic [2:0] opcode;
        logic [3:0] arg;
    } cmdView_t;

    // bit 7 decides which view applies.
    typedef union packed {
        chrView_t chr;
        cmdView_t cmd;
    } textByte_t;

endpackage

/* src/uartPkg.sv */
package uartPkg;

    // serial timing, kept short for simulation.
    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;  // start edge to middle of start bit.
    localparam int COUNT_W      = $clog2(CLKS_PER_BIT);

    // 8N1 frame.
    localparam int DATA_BITS  = 8;
    localparam int BIT_IDX_W  = $clog2(DATA_BITS);
    localparam int FRAME_BITS = DATA_BITS + 2;  // start, data, stop.
    localparam int FRAME_W    = $clog2(FRAME_BITS);

    // receiver states.
    localparam logic [2:0] RX_IDLE  = 3'd0;
    localparam logic [2:0] RX_START = 3'd1;
    localparam logic [2:0] RX_DATA  = 3'd2;
    localparam logic [2:0] RX_STOP  = 3'd3;
    localparam logic [2:0] RX_WAIT  = 3'd4;  // bad stop bit, wait for idle line.

endpackage
